//--- filelist.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_cmd_if.sv
hw/csr_access_decode.sv
hw/csr_reg_cell.sv
hw/csr_read_select.sv
hw/csr_unit.sv
verification/csr_unit_props.sv
verification/csr_unit_tb.sv

//--- hw/csr_access_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_access_decode (
    input  logic               valid,
    input  csr_pkg::csr_op_t   op,
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::xlen_t     src,
    input  csr_pkg::xlen_t     pc,
    csr_cmd_if.source          cmd,
    output logic               illegal,
    output logic               trap_taken,
    output logic               trap_return
);
    import csr_pkg::*;

    cell_sel_t hit;
    logic      ro_hit;
    logic      known;
    logic      is_csr_op;
    logic      ro_write;

    // Address match against the writable cells and the identity registers
    always_comb begin
        hit    = '0;
        ro_hit = 1'b0;
        case (addr)
            `CSR_ADDR_MEPC:      hit[0] = 1'b1;
            `CSR_ADDR_MCAUSE:    hit[1] = 1'b1;
            `CSR_ADDR_MSTATUS:   hit[2] = 1'b1;
            `CSR_ADDR_MTVEC:     hit[3] = 1'b1;
            `CSR_ADDR_MVENDORID: ro_hit = 1'b1;
            `CSR_ADDR_MARCHID:   ro_hit = 1'b1;
            default: begin
                hit    = '0;
                ro_hit = 1'b0;
            end
        endcase
    end

    assign known     = (|hit) | ro_hit;
    assign is_csr_op = valid && (op == `CSR_OP_RW || op == `CSR_OP_RS || op == `CSR_OP_RC);

    // csrrs and csrrc with a zero operand only read
    assign ro_write  = ro_hit && (op == `CSR_OP_RW || src != '0);

    assign illegal     = is_csr_op && (!known || ro_write);
    assign trap_taken  = valid && (op == `CSR_OP_ECALL);
    assign trap_return = valid && (op == `CSR_OP_MRET);

    // Unknown and read-only addresses never reach a cell
    assign cmd.write_sel = (is_csr_op && !illegal) ? hit : '0;
    assign cmd.write_op  = op;
    assign cmd.operand   = src;

    // ecall captures into mepc and mcause
    assign cmd.trap_sel = trap_taken ? cell_sel_t'(4'b0011) : '0;
    assign cmd.trap_pc  = {pc[`CSR_XLEN-1:2], 2'b00};

endmodule

`default_nettype wire

//--- hw/csr_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_cmd_if ();
    import csr_pkg::*;

    cell_sel_t write_sel;
    csr_op_t   write_op;
    xlen_t     operand;
    // Trap capture has priority over a normal write in the cells
    cell_sel_t trap_sel;
    xlen_t     trap_pc;

    modport source (
        output write_sel,
        output write_op,
        output operand,
        output trap_sel,
        output trap_pc
    );

    modport sink (
        input write_sel,
        input write_op,
        input operand,
        input trap_sel,
        input trap_pc
    );

endinterface

`default_nettype wire

//--- hw/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Widths and cell count
`define CSR_XLEN            32
`define CSR_ADDR_W          12
`define CSR_OP_W            3
`define CSR_CELLS           4

// Machine-mode CSR addresses
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12

// Operation codes from the core decoder
`define CSR_OP_NONE         3'd0
`define CSR_OP_RW           3'd1
`define CSR_OP_RS           3'd2
`define CSR_OP_RC           3'd3
`define CSR_OP_ECALL        3'd4
`define CSR_OP_MRET         3'd5

// Identity registers and trap cause
`define CSR_MVENDORID       32'h7973_7978
`define CSR_MARCHID         32'h016F_BCBD
`define CSR_CAUSE_ECALL     32'd11

`endif

//--- hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

`include "csr_config.svh"

    typedef logic [`CSR_XLEN-1:0]   xlen_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`CSR_OP_W-1:0]   csr_op_t;

    // Cell order: 0 mepc, 1 mcause, 2 mstatus, 3 mtvec
    typedef logic [`CSR_CELLS-1:0]  cell_sel_t;
    typedef xlen_t                  cell_bus_t [`CSR_CELLS];

    // mstatus comes up with MPP set to machine mode
    localparam cell_bus_t CELL_RESET = '{
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_1800,
        32'h0000_0000
    };

    // Only MIE and MPIE are writable in mstatus
    localparam cell_bus_t CELL_WMASK = '{
        32'hFFFF_FFFC,
        32'hFFFF_FFFF,
        32'h0000_0088,
        32'hFFFF_FFFC
    };

endpackage

`default_nettype wire

//--- hw/csr_read_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_read_select (
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::csr_op_t   op,
    input  csr_pkg::cell_bus_t cells,
    input  logic               trap_taken,
    input  logic               trap_return,
    output csr_pkg::xlen_t     rdata,
    output logic               redirect_valid,
    output csr_pkg::xlen_t     redirect_pc
);
    import csr_pkg::*;

    xlen_t lookup;
    logic  is_csr_op;

    always_comb begin
        case (addr)
            `CSR_ADDR_MEPC:      lookup = cells[0];
            `CSR_ADDR_MCAUSE:    lookup = cells[1];
            `CSR_ADDR_MSTATUS:   lookup = cells[2];
            `CSR_ADDR_MTVEC:     lookup = cells[3];
            `CSR_ADDR_MVENDORID: lookup = `CSR_MVENDORID;
            `CSR_ADDR_MARCHID:   lookup = `CSR_MARCHID;
            default:             lookup = '0;
        endcase
    end

    // ecall and mret return no data
    assign is_csr_op = (op == `CSR_OP_RW) || (op == `CSR_OP_RS) || (op == `CSR_OP_RC);
    assign rdata     = is_csr_op ? lookup : '0;

    // Direct mode only, so mtvec is the target as stored
    assign redirect_valid = trap_taken | trap_return;

    always_comb begin
        if (trap_taken) begin
            redirect_pc = cells[3];
        end else if (trap_return) begin
            redirect_pc = cells[0];
        end else begin
            redirect_pc = '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_reg_cell.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_reg_cell #(
    parameter int unsigned    INDEX     = 0,
    parameter csr_pkg::xlen_t RESET_VAL = '0,
    parameter csr_pkg::xlen_t WMASK     = '1
) (
    input  logic           clock,
    input  logic           reset,
    csr_cmd_if.sink        cmd,
    input  csr_pkg::xlen_t trap_val,
    output csr_pkg::xlen_t value
);
    import csr_pkg::*;

    xlen_t updated;
    xlen_t write_val;
    xlen_t trap_load;

    // Read-modify-write on the current value
    always_comb begin
        case (cmd.write_op)
            `CSR_OP_RW: updated = cmd.operand;
            `CSR_OP_RS: updated = value | cmd.operand;
            `CSR_OP_RC: updated = value & ~cmd.operand;
            default:    updated = value;
        endcase
    end

    // Bits outside the mask keep their old value
    assign write_val = (value & ~WMASK) | (updated & WMASK);
    assign trap_load = (value & ~WMASK) | (trap_val & WMASK);

    always_ff @(posedge clock) begin
        if (reset) begin
            value <= RESET_VAL;
        end else if (cmd.trap_sel[INDEX]) begin
            value <= trap_load;
        end else if (cmd.write_sel[INDEX]) begin
            value <= write_val;
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               valid,
    input  csr_pkg::csr_op_t   op,
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::xlen_t     src,
    input  csr_pkg::xlen_t     pc,
    output csr_pkg::xlen_t     rdata,
    output logic               illegal,
    output logic               redirect_valid,
    output csr_pkg::xlen_t     redirect_pc
);
    import csr_pkg::*;

    logic      trap_taken;
    logic      trap_return;
    cell_bus_t cells;
    cell_bus_t trap_vals;

    csr_cmd_if cmd ();

    csr_access_decode u_decode (
        .valid       (valid),
        .op          (op),
        .addr        (addr),
        .src         (src),
        .pc          (pc),
        .cmd         (cmd),
        .illegal     (illegal),
        .trap_taken  (trap_taken),
        .trap_return (trap_return)
    );

    // Trap capture data per cell, only mepc and mcause take a trap
    assign trap_vals[0] = cmd.trap_pc;
    assign trap_vals[1] = `CSR_CAUSE_ECALL;
    assign trap_vals[2] = '0;
    assign trap_vals[3] = '0;

    for (genvar i = 0; i < `CSR_CELLS; i++) begin : g_cell
        csr_reg_cell #(
            .INDEX     (i),
            .RESET_VAL (CELL_RESET[i]),
            .WMASK     (CELL_WMASK[i])
        ) u_cell (
            .clock    (clock),
            .reset    (reset),
            .cmd      (cmd),
            .trap_val (trap_vals[i]),
            .value    (cells[i])
        );
    end

    csr_read_select u_read (
        .addr           (addr),
        .op             (op),
        .cells          (cells),
        .trap_taken     (trap_taken),
        .trap_return    (trap_return),
        .rdata          (rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    --top-module csr_unit_tb \
    -f filelist.f \
    --Mdir obj_dir \
    -o csr_unit_sim

./obj_dir/csr_unit_sim | tee sim.log

if grep -q "^sim passed$" sim.log; then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation failed"
    exit 1
fi

//--- verification/csr_unit_props.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_props (
    input logic               clock,
    input logic               reset,
    input logic               valid,
    input logic               illegal,
    input logic               redirect_valid,
    input csr_pkg::cell_sel_t write_sel,
    input csr_pkg::xlen_t     mstatus_value
);

    // A redirect only comes with a strobe
    a_redirect_needs_valid : assert property (
        @(posedge clock) disable iff (reset) redirect_valid |-> valid
    ) else $error("redirect_valid asserted while valid is low");

    // Traps are never illegal accesses
    a_redirect_not_illegal : assert property (
        @(posedge clock) disable iff (reset) !(redirect_valid && illegal)
    ) else $error("redirect_valid and illegal asserted together");

    a_write_sel_onehot : assert property (
        @(posedge clock) disable iff (reset) $onehot0(write_sel)
    ) else $error("write_sel selects more than one cell");

    // First edge out of reset sees MPP set to machine mode
    a_mstatus_reset : assert property (
        @(posedge clock) $fell(reset) |-> (mstatus_value == 32'h0000_1800)
    ) else $error("mstatus does not hold its reset value after reset");

endmodule

bind csr_unit csr_unit_props u_props (
    .clock          (clock),
    .reset          (reset),
    .valid          (valid),
    .illegal        (illegal),
    .redirect_valid (redirect_valid),
    .write_sel      (cmd.write_sel),
    .mstatus_value  (cells[2])
);

`default_nettype wire

//--- verification/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_unit_tb;

    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 300;
    localparam int N_ILLEGAL    = 40;
    localparam int N_TRAP       = 20;
    localparam int N_IDLE       = 40;
    // Reset plus roughly 850 test cycles, doubled with margin
    localparam int MAX_CYCLES   = 2000;

    localparam logic [31:0] MASK [4] = '{
        32'hFFFF_FFFC, 32'hFFFF_FFFF, 32'h0000_0088, 32'hFFFF_FFFC
    };
    localparam logic [31:0] RESET_VALS [4] = '{
        32'h0000_0000, 32'h0000_0000, 32'h0000_1800, 32'h0000_0000
    };

    logic        clock;
    logic        reset;
    logic        valid;
    logic [2:0]  op;
    logic [11:0] addr;
    logic [31:0] src;
    logic [31:0] pc;
    logic [31:0] rdata;
    logic        illegal;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    // Reference copy of mepc, mcause, mstatus, mtvec
    logic [31:0] model [4];
    logic [31:0] rng_state;
    int          cycle_count;
    int          check_count;
    int          error_count;
    int          test_num;

    csr_unit UUT (
        .clock          (clock),
        .reset          (reset),
        .valid          (valid),
        .op             (op),
        .addr           (addr),
        .src            (src),
        .pc             (pc),
        .rdata          (rdata),
        .illegal        (illegal),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // -1 when the address is not a writable CSR
    function automatic int cell_index(input logic [11:0] a);
        case (a)
            `CSR_ADDR_MEPC:    return 0;
            `CSR_ADDR_MCAUSE:  return 1;
            `CSR_ADDR_MSTATUS: return 2;
            `CSR_ADDR_MTVEC:   return 3;
            default:           return -1;
        endcase
    endfunction

    function automatic logic [11:0] cell_addr(input int i);
        case (i)
            0:       return `CSR_ADDR_MEPC;
            1:       return `CSR_ADDR_MCAUSE;
            2:       return `CSR_ADDR_MSTATUS;
            default: return `CSR_ADDR_MTVEC;
        endcase
    endfunction

    function automatic logic is_identity(input logic [11:0] a);
        return (a == `CSR_ADDR_MVENDORID) || (a == `CSR_ADDR_MARCHID);
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] a);
        int idx;
        idx = cell_index(a);
        if (idx >= 0) return model[idx];
        if (a == `CSR_ADDR_MVENDORID) return `CSR_MVENDORID;
        if (a == `CSR_ADDR_MARCHID) return `CSR_MARCHID;
        return 32'h0;
    endfunction

    function automatic logic [2:0] csr_op_from(input logic [1:0] sel);
        case (sel)
            2'd1:    return `CSR_OP_RS;
            2'd2:    return `CSR_OP_RC;
            default: return `CSR_OP_RW;
        endcase
    endfunction

    function automatic logic [11:0] unknown_addr();
        logic [31:0] r;
        r = next_rand();
        while (cell_index(r[11:0]) >= 0 || is_identity(r[11:0])) begin
            r = next_rand();
        end
        return r[11:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    // One access cycle, entered 1 ns after a rising edge
    task automatic access(input logic v, input logic [2:0] o, input logic [11:0] a,
                          input logic [31:0] s, input logic [31:0] p);
        int          idx;
        logic        csr_op;
        logic        ro;
        logic        exp_illegal;
        logic        exp_redirect;
        logic [31:0] exp_rdata;
        logic [31:0] exp_target;
        logic [31:0] updated;
        valid = v;
        op    = o;
        addr  = a;
        src   = s;
        pc    = p;
        idx    = cell_index(a);
        ro     = is_identity(a);
        csr_op = (o == `CSR_OP_RW) || (o == `CSR_OP_RS) || (o == `CSR_OP_RC);
        exp_rdata    = csr_op ? model_read(a) : 32'h0;
        exp_illegal  = v && csr_op && ((idx < 0 && !ro) ||
                       (ro && (o == `CSR_OP_RW || s != 32'h0)));
        exp_redirect = v && (o == `CSR_OP_ECALL || o == `CSR_OP_MRET);
        exp_target   = 32'h0;
        if (v && o == `CSR_OP_ECALL) exp_target = model[3];
        else if (v && o == `CSR_OP_MRET) exp_target = model[0];

        @(negedge clock);
        if (v) check_value("rdata", rdata, exp_rdata);
        check_value("illegal", 32'(illegal), 32'(exp_illegal));
        check_value("redirect_valid", 32'(redirect_valid), 32'(exp_redirect));
        check_value("redirect_pc", redirect_pc, exp_target);

        @(posedge clock);
        if (v && o == `CSR_OP_ECALL) begin
            model[0] = {p[31:2], 2'b00};
            model[1] = `CSR_CAUSE_ECALL;
        end else if (v && csr_op && !exp_illegal && idx >= 0) begin
            case (o)
                `CSR_OP_RW: updated = s;
                `CSR_OP_RS: updated = model[idx] | s;
                default:    updated = model[idx] & ~s;
            endcase
            model[idx] = (model[idx] & ~MASK[idx]) | (updated & MASK[idx]);
        end
        #1;
    endtask

    task automatic read_reg(input logic [11:0] a);
        access(1'b1, `CSR_OP_RS, a, 32'h0, 32'h0);
    endtask

    task automatic verify_regs();
        for (int i = 0; i < 4; i++) begin
            read_reg(cell_addr(i));
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, error_count - errors_before);
    endtask

    initial begin
        int          base;
        logic [31:0] r;
        logic [11:0] a;
        clock = 1'b0;
        reset = 1'b1;
        valid = 1'b0;
        op    = `CSR_OP_NONE;
        addr  = 12'h0;
        src   = 32'h0;
        pc    = 32'h0;
        rng_state   = 32'd64935;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        test_num    = 0;
        for (int i = 0; i < 4; i++) model[i] = RESET_VALS[i];
        repeat (RESET_CYCLES) @(posedge clock);
        #1 reset = 1'b0;

        base = error_count;
        verify_regs();
        read_reg(`CSR_ADDR_MVENDORID);
        read_reg(`CSR_ADDR_MARCHID);
        finish_test("reset values", base);

        // Each write is followed by a read of the same CSR
        base = error_count;
        for (int i = 0; i < N_RANDOM; i++) begin
            r = next_rand();
            a = cell_addr(int'(r[1:0]));
            access(1'b1, csr_op_from(r[3:2]), a, next_rand(), 32'h0);
            read_reg(a);
        end
        finish_test("random csr access", base);

        base = error_count;
        for (int i = 0; i < N_ILLEGAL; i++) begin
            r = next_rand();
            if (r[4]) begin
                access(1'b1, csr_op_from(r[1:0]), unknown_addr(), next_rand(), next_rand());
            end else begin
                a = r[5] ? `CSR_ADDR_MARCHID : `CSR_ADDR_MVENDORID;
                access(1'b1, `CSR_OP_RW, a, next_rand(), 32'h0);
            end
        end
        verify_regs();
        finish_test("illegal access", base);

        base = error_count;
        for (int i = 0; i < N_TRAP; i++) begin
            access(1'b1, `CSR_OP_RW, `CSR_ADDR_MTVEC, next_rand(), 32'h0);
            access(1'b1, `CSR_OP_ECALL, 12'h0, 32'h0, next_rand());
            read_reg(`CSR_ADDR_MEPC);
            read_reg(`CSR_ADDR_MCAUSE);
        end
        finish_test("ecall", base);

        base = error_count;
        for (int i = 0; i < N_TRAP; i++) begin
            access(1'b1, `CSR_OP_RW, `CSR_ADDR_MEPC, next_rand(), 32'h0);
            access(1'b1, `CSR_OP_MRET, 12'h0, 32'h0, next_rand());
        end
        verify_regs();
        finish_test("mret", base);

        // Random inputs with the strobe low must leave every register alone
        base = error_count;
        for (int i = 0; i < N_IDLE; i++) begin
            r = next_rand();
            a = r[12] ? cell_addr(int'(r[9:8])) : r[31:20];
            access(1'b0, r[2:0], a, next_rand(), next_rand());
        end
        verify_regs();
        finish_test("idle cycles", base);

        valid = 1'b0;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
